//--- project.f
+incdir+.
ecc_pkg.sv
wb_pkg.sv
ecc_write_port.sv
codeword_fifo.sv
ecc_read_port.sv
ecc_fifo_top.sv
ecc_fifo_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f project.f --top-module ecc_fifo_tb -o ecc_fifo_sim \
   && ./obj_dir/ecc_fifo_sim \
   || exit 1

//--- ecc_ref.svh
// secded reference model and lfsr
// included inside the testbench module

`ifndef ecc_ref_svh
`define ecc_ref_svh

   logic [31:0] lfsr_state = 32'hf1c8_5844;

   // galois lfsr, one step per bit handed out
   function automatic logic lfsr_step();
      logic out;
      out = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0000_0000);
      return out;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsr_step()};
      end
      return val;
   endfunction

   // n distinct flipped positions anywhere in the 39 bit codeword
   function automatic logic [ecc_pkg::code_w-1:0] flip_mask(input int flips);
      logic [ecc_pkg::code_w-1:0] mask;
      int                         pos;
      mask = '0;
      while ($countones(mask) < flips) begin
         pos  = int'(rand_bits(6) % 32'd39);
         mask = mask | ((ecc_pkg::code_w)'(1) << pos);
      end
      return mask;
   endfunction

   // flag class expected from the number of injected flips
   function automatic logic [1:0] flip_class(input logic [ecc_pkg::code_w-1:0] mask);
      return 2'($countones(mask));
   endfunction

`endif

//--- ecc_fifo_tb.sv
// ecc queue testbench

`timescale 1ns/1ns
`default_nettype none

module ecc_fifo_tb;

   localparam int clk_period = 100;
   localparam int n_trans    = 162;   // 81 writes and 81 reads

   typedef struct packed {
      logic [ecc_pkg::data_w-1:0] data;
      logic [1:0]                 cls;   // 0 clean, 1 single, 2 double
   } expect_t;

   logic                  clk = 1'b0;
   logic                  rst_l;
   wb_pkg::wb_write_req_t wr_req;
   logic                  wr_ack;
   wb_pkg::wb_read_req_t  rd_req;
   wb_pkg::wb_read_rsp_t  rd_rsp;
   expect_t               sb [$];
   logic                  wr_pending;
   logic                  rd_pending;

   `include "ecc_ref.svh"

   ecc_fifo_top i_dut (
      .clk    (clk),
      .rst_l  (rst_l),
      .wr_req (wr_req),
      .wr_ack (wr_ack),
      .rd_req (rd_req),
      .rd_rsp (rd_rsp)
   );

   always #(clk_period/2) clk = ~clk;

   task automatic stop_run(input string line);
      $display("%s", line);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   // fast asks for an ack one cycle after the request is seen
   task automatic write_word(input logic [31:0] data, input logic [38:0] mask, input bit fast);
      int      cycles;
      expect_t e;
      wr_pending = 1'b1;
      @(posedge clk);
      wr_req <= '{cyc: 1'b1, stb: 1'b1, dat: data, inject: mask};
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!wr_ack);
      wr_req <= '0;
      e.data = data;
      e.cls  = flip_class(mask);
      sb.push_back(e);
      wr_pending = 1'b0;
      assert (!fast || cycles == 2)
         else stop_run($sformatf("MISMATCH at %0t ns: write ack %0d cycles after request, expected 1",
                                 $time, cycles - 1));
   endtask

   task automatic read_word(input bit fast);
      int      cycles;
      expect_t e;
      rd_pending = 1'b1;
      @(posedge clk);
      rd_req <= '{cyc: 1'b1, stb: 1'b1};
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!rd_rsp.ack);
      rd_req <= '0;
      rd_pending = 1'b0;
      assert (sb.size() != 0) else stop_run("read returned a word that was never written");
      e = sb.pop_front();
      assert (!fast || cycles == 2)
         else stop_run($sformatf("MISMATCH at %0t ns: read ack %0d cycles after request, expected 1",
                                 $time, cycles - 1));
      assert (e.cls == 2'd2 || rd_rsp.dat == e.data)   // double error data is raw
         else stop_run($sformatf("MISMATCH at %0t ns: read data %h, expected %h",
                                 $time, rd_rsp.dat, e.data));
      assert (rd_rsp.single_err == (e.cls == 2'd1))
         else stop_run($sformatf("MISMATCH at %0t ns: single_err %b for %0d flips",
                                 $time, rd_rsp.single_err, e.cls));
      assert (rd_rsp.double_err == (e.cls == 2'd2))
         else stop_run($sformatf("MISMATCH at %0t ns: double_err %b for %0d flips",
                                 $time, rd_rsp.double_err, e.cls));
   endtask

   initial begin
      #(n_trans * 200 * clk_period);
      stop_run("watchdog expired before all transactions completed");
   end

   initial begin
      wr_req     = '0;
      rd_req     = '0;
      rst_l      = 1'b0;
      wr_pending = 1'b0;
      rd_pending = 1'b0;
      repeat (2) @(posedge clk);
      rst_l <= 1'b1;

      // clean bursts with order checked through the scoreboard
      for (int b = 0; b < 4; b++) begin
         for (int i = 0; i < 4; i++) write_word(rand_bits(32), '0, 1'b1);
         for (int i = 0; i < 4; i++) read_word(1'b1);
      end

      for (int p = 0; p < ecc_pkg::code_w; p++) begin   // every single bit incl. check and parity
         write_word(rand_bits(32), (ecc_pkg::code_w)'(1) << p, 1'b1);
         read_word(1'b1);
      end

      for (int i = 0; i < 16; i++) begin
         write_word(rand_bits(32), flip_mask(2), 1'b1);
         read_word(1'b1);
      end

      // fill the queue so that one more write has to wait for a pop
      for (int i = 0; i < ecc_pkg::fifo_depth; i++) write_word(rand_bits(32), '0, 1'b1);
      fork
         write_word(rand_bits(32), '0, 1'b0);
         begin
            repeat (22) @(posedge clk);   // 20 cycles after the request is first seen
            assert (wr_pending && !wr_ack)
               else stop_run("write was acknowledged while the queue was full");
            read_word(1'b1);
         end
      join
      for (int i = 0; i < ecc_pkg::fifo_depth; i++) read_word(1'b1);

      // the queue is empty now and the read waits for the next write
      fork
         read_word(1'b0);
         begin
            repeat (22) @(posedge clk);
            assert (rd_pending && !rd_rsp.ack)
               else stop_run("read was acknowledged on an empty queue");
            write_word(rand_bits(32), '0, 1'b1);
         end
      join

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- ecc_fifo_top.sv
// ecc protected queue top

`timescale 1ns/1ns
`default_nettype none

module ecc_fifo_top (
   input  logic                  clk,
   input  logic                  rst_l,
   input  wb_pkg::wb_write_req_t wr_req,
   output logic                  wr_ack,
   input  wb_pkg::wb_read_req_t  rd_req,
   output wb_pkg::wb_read_rsp_t  rd_rsp
);

   logic               push;
   logic               pop;
   logic               full;
   logic               empty;
   ecc_pkg::codeword_t push_word;
   ecc_pkg::codeword_t head;

   ecc_write_port i_write_port (
      .clk       (clk),
      .rst_l     (rst_l),
      .wr_req    (wr_req),
      .wr_ack    (wr_ack),
      .full      (full),
      .push      (push),
      .push_word (push_word)
   );

   codeword_fifo i_fifo (
      .clk       (clk),
      .rst_l     (rst_l),
      .push      (push),
      .push_word (push_word),
      .pop       (pop),
      .head      (head),
      .full      (full),
      .empty     (empty)
   );

   ecc_read_port i_read_port (
      .clk    (clk),
      .rst_l  (rst_l),
      .rd_req (rd_req),
      .rd_rsp (rd_rsp),
      .head   (head),
      .empty  (empty),
      .pop    (pop)
   );

endmodule

`default_nettype wire

//--- ecc_read_port.sv
// wishbone read slave with secded decode

`timescale 1ns/1ns
`default_nettype none

module ecc_read_port (
   input  logic                 clk,
   input  logic                 rst_l,
   input  wb_pkg::wb_read_req_t rd_req,
   output wb_pkg::wb_read_rsp_t rd_rsp,
   input  ecc_pkg::codeword_t   head,
   input  logic                 empty,
   output logic                 pop
);

   logic [ecc_pkg::check_w-1:0]   recomputed;
   logic [ecc_pkg::hamming_w-1:0] syndrome;
   logic                          parity_err;
   logic                          single_err;
   logic                          double_err;
   logic [ecc_pkg::code_w-1:0]    layout;
   logic [ecc_pkg::code_w-1:0]    error_mask;
   logic [ecc_pkg::code_w-1:0]    fixed;
   logic [ecc_pkg::data_w-1:0]    fixed_data;
   logic                          accept;

   logic                          rsp_ack;
   logic [ecc_pkg::data_w-1:0]    rsp_dat;
   logic                          rsp_single;
   logic                          rsp_double;

   assign recomputed = ecc_pkg::ecc_check_bits(head.data);
   assign syndrome   = recomputed[ecc_pkg::hamming_w-1:0] ^ head.check[ecc_pkg::hamming_w-1:0];
   assign parity_err = ^head;   // odd weight over all 39 bits

   // odd parity means one flip, even parity with a syndrome means two
   assign single_err = parity_err;
   assign double_err = ~parity_err & (syndrome != '0);

   // hamming order, check bits at the power of two positions
   assign layout = {head.check[6], head.data[31:26], head.check[5], head.data[25:11],
                    head.check[4], head.data[10:4], head.check[3], head.data[3:1],
                    head.check[2], head.data[0], head.check[1:0]};

   always_comb begin
      for (int i = 1; i <= ecc_pkg::code_w; i++) begin
         error_mask[i-1] = (syndrome == ecc_pkg::hamming_w'(i));
      end
   end

   // a parity bit flip gives a zero syndrome, so the data stays as is
   assign fixed      = single_err ? (layout ^ error_mask) : layout;
   assign fixed_data = {fixed[37:32], fixed[30:16], fixed[14:8], fixed[6:4], fixed[2]};

   assign accept = rd_req.cyc & rd_req.stb & ~empty & ~rsp_ack;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rsp_ack    <= 1'b0;
         rsp_single <= 1'b0;
         rsp_double <= 1'b0;
         pop        <= 1'b0;
      end
      else begin
         rsp_ack <= accept;
         pop     <= accept;   // head moves on after the response is taken
         if (accept) begin
            rsp_single <= single_err;
            rsp_double <= double_err;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rsp_dat <= fixed_data;
      end
   end

   assign rd_rsp = '{ack: rsp_ack, dat: rsp_dat, single_err: rsp_single, double_err: rsp_double};

endmodule

`default_nettype wire

//--- codeword_fifo.sv
// circular codeword queue

`timescale 1ns/1ns
`default_nettype none

module codeword_fifo (
   input  logic               clk,
   input  logic               rst_l,
   input  logic               push,
   input  ecc_pkg::codeword_t push_word,
   input  logic               pop,
   output ecc_pkg::codeword_t head,
   output logic               full,
   output logic               empty
);

   ecc_pkg::codeword_t           mem [ecc_pkg::fifo_depth];
   logic [ecc_pkg::ptr_w-1:0]    wr_ptr;
   logic [ecc_pkg::ptr_w-1:0]    rd_ptr;
   logic [ecc_pkg::ptr_w:0]      count;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_word;
      end
   end

   // depth is a power of two, pointers wrap on their own
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle, or push and pop together
         endcase
      end
   end

   assign head  = mem[rd_ptr];   // oldest entry
   assign full  = (count == (ecc_pkg::ptr_w+1)'(ecc_pkg::fifo_depth));
   assign empty = (count == '0);

endmodule

`default_nettype wire

//--- ecc_write_port.sv
// wishbone write slave with ecc encode

`timescale 1ns/1ns
`default_nettype none

module ecc_write_port (
   input  logic                  clk,
   input  logic                  rst_l,
   input  wb_pkg::wb_write_req_t wr_req,
   output logic                  wr_ack,
   input  logic                  full,
   output logic                  push,
   output ecc_pkg::codeword_t    push_word
);

   logic               req;
   logic               accept;
   ecc_pkg::codeword_t enc;

   assign req = wr_req.cyc & wr_req.stb;

   // wr_ack high means this request is already done, wait for the master to drop it
   assign accept = req & ~full & ~wr_ack;

   assign enc.data  = wr_req.dat;
   assign enc.check = ecc_pkg::ecc_check_bits(wr_req.dat);

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         wr_ack <= 1'b0;
         push   <= 1'b0;
      end
      else begin
         wr_ack <= accept;   // single cycle ack
         push   <= accept;
      end
   end

   // injection mask flips stored bits for error test
   always_ff @(posedge clk) begin
      if (accept) begin
         push_word <= enc ^ wr_req.inject;
      end
   end

endmodule

`default_nettype wire

//--- wb_pkg.sv
// wishbone classic port types

`default_nettype none

package wb_pkg;

   // write port request, inject lines up bit for bit with codeword_t
   typedef struct packed {
      logic                        cyc;
      logic                        stb;
      logic [ecc_pkg::data_w-1:0]  dat;
      logic [ecc_pkg::code_w-1:0]  inject;
   } wb_write_req_t;

   // read port request, no data travels toward the slave
   typedef struct packed {
      logic cyc;
      logic stb;
   } wb_read_req_t;

   typedef struct packed {
      logic                        ack;
      logic [ecc_pkg::data_w-1:0]  dat;
      logic                        single_err;   // corrected
      logic                        double_err;   // uncorrectable, dat is raw
   } wb_read_rsp_t;

endpackage

`default_nettype wire

//--- ecc_pkg.sv
// secded code definitions
// widths, hamming masks, codeword type

`default_nettype none

package ecc_pkg;

   localparam int data_w    = 32;
   localparam int hamming_w = 6;
   localparam int check_w   = hamming_w + 1;   // hamming bits plus overall parity
   localparam int code_w    = data_w + check_w;

   localparam int fifo_depth = 8;
   localparam int ptr_w      = $clog2(fifo_depth);

   // data bits feeding each hamming bit, index 0 is the lowest hamming bit
   localparam logic [hamming_w-1:0][data_w-1:0] ecc_masks = {
      32'hfc00_0000,   // h5
      32'h03ff_f800,   // h4
      32'h03fc_07f0,   // h3
      32'he3c3_c78e,   // h2
      32'h9b33_366d,   // h1
      32'h56aa_ad5b    // h0
   };

   typedef struct packed {
      logic [data_w-1:0]  data;
      logic [check_w-1:0] check;   // {parity, hamming[5:0]}
   } codeword_t;

   // check bits for a data word, bit 6 makes the whole codeword even
   function automatic logic [check_w-1:0] ecc_check_bits(input logic [data_w-1:0] data);
      logic [hamming_w-1:0] ham;
      for (int k = 0; k < hamming_w; k++) begin
         ham[k] = ^(data & ecc_masks[k]);
      end
      return {(^data) ^ (^ham), ham};
   endfunction

endpackage

`default_nettype wire
